// File: filelist.f
rtl/dec_pkg.sv
rtl/int_dec.sv
rtl/imm_gen.sv
rtl/mem_dec.sv
rtl/dec_stage_reg.sv
rtl/dec_top.sv
verif/dec_tb_checker.sv
verif/dec_tb.sv

// File: rtl/dec_pkg.sv
`default_nettype none

package dec_pkg;

    localparam int unsigned INST_LEN = 32;

    // instruction bits 6:2, RV32 base opcode map
    typedef enum logic [4:0] {
        OP_LOAD      = 5'b00000,
        OP_LOAD_FP   = 5'b00001,
        OP_CUST_0    = 5'b00010,
        OP_MISC_MEM  = 5'b00011,
        OP_OP_IMM    = 5'b00100,
        OP_AUIPC     = 5'b00101,
        OP_OP_IMM_32 = 5'b00110,
        OP_STORE     = 5'b01000,
        OP_STORE_FP  = 5'b01001,
        OP_CUST_1    = 5'b01010,
        OP_AMO       = 5'b01011,
        OP_OP        = 5'b01100,
        OP_LUI       = 5'b01101,
        OP_OP_32     = 5'b01110,
        OP_MADD      = 5'b10000,
        OP_MSUB      = 5'b10001,
        OP_NMSUB     = 5'b10010,
        OP_NMADD     = 5'b10011,
        OP_OP_FP     = 5'b10100,
        OP_CUST_2    = 5'b10110,
        OP_BRANCH    = 5'b11000,
        OP_JALR      = 5'b11001,
        OP_JAL       = 5'b11011,
        OP_SYSTEM    = 5'b11100,
        OP_CUST_3    = 5'b11110
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

    // load and store widths
    localparam logic [2:0] FUNCT3_LB   = 3'b000;
    localparam logic [2:0] FUNCT3_LH   = 3'b001;
    localparam logic [2:0] FUNCT3_LW   = 3'b010;
    localparam logic [2:0] FUNCT3_LBU  = 3'b100;
    localparam logic [2:0] FUNCT3_LHU  = 3'b101;
    localparam logic [2:0] FUNCT3_SB   = 3'b000;
    localparam logic [2:0] FUNCT3_SH   = 3'b001;
    localparam logic [2:0] FUNCT3_SW   = 3'b010;

    // branch conditions
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    // register and immediate ALU operations
    localparam logic [2:0] FUNCT3_ADD  = 3'b000;
    localparam logic [2:0] FUNCT3_SLL  = 3'b001;
    localparam logic [2:0] FUNCT3_SLT  = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU = 3'b011;
    localparam logic [2:0] FUNCT3_XOR  = 3'b100;
    localparam logic [2:0] FUNCT3_SRL  = 3'b101;
    localparam logic [2:0] FUNCT3_OR   = 3'b110;
    localparam logic [2:0] FUNCT3_AND  = 3'b111;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    // selects SUB and SRA
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    typedef struct packed {
        alu_op_e alu_op;
        logic    rs1_zero_sel;
        logic    rs2_imm_sel;
        logic    pc_imm_sel;
        logic    pc_alu_sel;
        logic    branch;
        logic    branch_zcmp;
        logic    jump;
        logic    jump_alu;
        logic    mem_req;
        logic    mem_wr;
        logic    mem_cal_sel;
        logic    reg_wr;
    } ctrl_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
        logic [1:0] low_bits;
    } inst_fields_t;

endpackage

`default_nettype wire

// File: rtl/dec_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module dec_stage_reg #(
    parameter int XLEN = 32
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              valid_i,
    input  dec_pkg::ctrl_t    ctrl_i,
    input  logic [XLEN-1:0]   imm_i,
    input  logic [XLEN/8-1:0] mem_byte_i,
    input  logic              mem_sign_ext_i,
    input  logic              op_ill_i,
    input  logic              width_ill_i,
    output logic              valid_o,
    output dec_pkg::ctrl_t    ctrl_o,
    output logic [XLEN-1:0]   imm_o,
    output logic [XLEN/8-1:0] mem_byte_o,
    output logic              mem_sign_ext_o,
    output logic              ill_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o        <= 1'b0;
            ctrl_o         <= '0;
            imm_o          <= '0;
            mem_byte_o     <= '0;
            mem_sign_ext_o <= 1'b0;
            ill_o          <= 1'b0;
        end else if (valid_i) begin
            valid_o        <= 1'b1;
            ctrl_o         <= ctrl_i;
            imm_o          <= imm_i;
            mem_byte_o     <= mem_byte_i;
            mem_sign_ext_o <= mem_sign_ext_i;
            ill_o          <= op_ill_i | width_ill_i;
        end else begin
            // bubble, nothing leaks from a stale instruction
            valid_o        <= 1'b0;
            ctrl_o         <= '0;
            imm_o          <= '0;
            mem_byte_o     <= '0;
            mem_sign_ext_o <= 1'b0;
            ill_o          <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dec_top.sv
`timescale 1ns/1ps
`default_nettype none

module dec_top #(
    parameter int XLEN = 32
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic [dec_pkg::INST_LEN-1:0] inst_i,
    input  logic                         inst_valid_i,
    output logic                         dec_valid_o,
    output dec_pkg::ctrl_t               ctrl_o,
    output logic [XLEN-1:0]              imm_o,
    output logic [XLEN/8-1:0]            mem_byte_o,
    output logic                         mem_sign_ext_o,
    output logic                         ill_inst_o
);

    import dec_pkg::*;

    inst_fields_t      fields;
    ctrl_t             ctrl;
    imm_fmt_e          imm_fmt;
    logic              is_mem;
    logic              op_ill;
    logic [XLEN-1:0]   imm;
    logic [XLEN/8-1:0] mem_byte;
    logic              mem_sign_ext;
    logic              width_ill;

    assign fields = inst_fields_t'(inst_i);

    int_dec u_int_dec (
        .fields_i  (fields),
        .ctrl_o    (ctrl),
        .imm_fmt_o (imm_fmt),
        .is_mem_o  (is_mem),
        .op_ill_o  (op_ill)
    );

    imm_gen #(
        .XLEN (XLEN)
    ) u_imm_gen (
        .fields_i (fields),
        .fmt_i    (imm_fmt),
        .imm_o    (imm)
    );

    mem_dec #(
        .XLEN (XLEN)
    ) u_mem_dec (
        .funct3_i       (fields.funct3),
        .is_mem_i       (is_mem),
        .store_i        (ctrl.mem_wr),
        .mem_byte_o     (mem_byte),
        .mem_sign_ext_o (mem_sign_ext),
        .width_ill_o    (width_ill)
    );

    dec_stage_reg #(
        .XLEN (XLEN)
    ) u_dec_stage_reg (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .valid_i        (inst_valid_i),
        .ctrl_i         (ctrl),
        .imm_i          (imm),
        .mem_byte_i     (mem_byte),
        .mem_sign_ext_i (mem_sign_ext),
        .op_ill_i       (op_ill),
        .width_ill_i    (width_ill),
        .valid_o        (dec_valid_o),
        .ctrl_o         (ctrl_o),
        .imm_o          (imm_o),
        .mem_byte_o     (mem_byte_o),
        .mem_sign_ext_o (mem_sign_ext_o),
        .ill_o          (ill_inst_o)
    );

endmodule

`default_nettype wire

// File: rtl/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen #(
    parameter int XLEN = 32
) (
    input  dec_pkg::inst_fields_t fields_i,
    input  dec_pkg::imm_fmt_e     fmt_i,
    output logic [XLEN-1:0]       imm_o
);

    import dec_pkg::*;

    logic [INST_LEN-1:0] raw;
    logic                sgn;

    assign raw = fields_i;
    assign sgn = raw[31];

    always_comb begin
        case (fmt_i)
            IMM_I: begin
                imm_o = {{(XLEN-11){sgn}}, raw[30:20]};
            end
            IMM_S: begin
                imm_o = {{(XLEN-11){sgn}}, raw[30:25], raw[11:7]};
            end
            // B and J offsets are in half-words
            IMM_B: begin
                imm_o = {{(XLEN-12){sgn}}, raw[7], raw[30:25], raw[11:8], 1'b0};
            end
            IMM_U: begin
                imm_o = {{(XLEN-31){sgn}}, raw[30:12], 12'b0};
            end
            IMM_J: begin
                imm_o = {{(XLEN-20){sgn}}, raw[19:12], raw[20], raw[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/int_dec.sv
`timescale 1ns/1ps
`default_nettype none

module int_dec (
    input  dec_pkg::inst_fields_t fields_i,
    output dec_pkg::ctrl_t        ctrl_o,
    output dec_pkg::imm_fmt_e     imm_fmt_o,
    output logic                  is_mem_o,
    output logic                  op_ill_o
);

    import dec_pkg::*;

    logic rd_nz;

    assign rd_nz = |fields_i.rd;

    // base ALU op shared by OP and OP-IMM
    function automatic alu_op_e alu_base(input logic [2:0] funct3);
        alu_op_e op;
        case (funct3)
            FUNCT3_ADD:  op = ALU_ADD;
            FUNCT3_SLL:  op = ALU_SLL;
            FUNCT3_SLT:  op = ALU_SLT;
            FUNCT3_SLTU: op = ALU_SLTU;
            FUNCT3_XOR:  op = ALU_XOR;
            FUNCT3_SRL:  op = ALU_SRL;
            FUNCT3_OR:   op = ALU_OR;
            default:     op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl_o    = '0;
        imm_fmt_o = IMM_NONE;
        is_mem_o  = 1'b0;
        op_ill_o  = (fields_i.low_bits != 2'b11);
        case (fields_i.opcode)
            OP_LOAD, OP_STORE: begin
                imm_fmt_o           = fields_i.opcode == OP_STORE ? IMM_S : IMM_I;
                is_mem_o            = 1'b1;
                ctrl_o.alu_op       = ALU_ADD;
                ctrl_o.rs1_zero_sel = 1'b1;
                ctrl_o.mem_req      = 1'b1;
                ctrl_o.mem_wr       = fields_i.opcode == OP_STORE;
                ctrl_o.mem_cal_sel  = fields_i.opcode == OP_LOAD;
                ctrl_o.reg_wr       = fields_i.opcode == OP_LOAD && rd_nz;
            end
            OP_OP_IMM: begin
                imm_fmt_o           = IMM_I;
                ctrl_o.alu_op       = alu_base(fields_i.funct3);
                ctrl_o.rs1_zero_sel = 1'b1;
                ctrl_o.reg_wr       = rd_nz;
                // only the shifts carry a funct7 field
                if (fields_i.funct3 == FUNCT3_SLL) begin
                    op_ill_o = op_ill_o | (fields_i.funct7 != FUNCT7_BASE);
                end else if (fields_i.funct3 == FUNCT3_SRL) begin
                    if (fields_i.funct7 == FUNCT7_ALT) begin
                        ctrl_o.alu_op = ALU_SRA;
                    end else if (fields_i.funct7 != FUNCT7_BASE) begin
                        op_ill_o = 1'b1;
                    end
                end
            end
            OP_OP: begin
                ctrl_o.alu_op       = alu_base(fields_i.funct3);
                ctrl_o.rs1_zero_sel = 1'b1;
                ctrl_o.rs2_imm_sel  = 1'b1;
                ctrl_o.reg_wr       = rd_nz;
                if (fields_i.funct7 == FUNCT7_ALT && fields_i.funct3 == FUNCT3_ADD) begin
                    ctrl_o.alu_op = ALU_SUB;
                end else if (fields_i.funct7 == FUNCT7_ALT && fields_i.funct3 == FUNCT3_SRL) begin
                    ctrl_o.alu_op = ALU_SRA;
                end else if (fields_i.funct7 != FUNCT7_BASE) begin
                    op_ill_o = 1'b1;
                end
            end
            OP_LUI: begin
                // zero plus immediate through the OR path
                imm_fmt_o     = IMM_U;
                ctrl_o.alu_op = ALU_OR;
                ctrl_o.reg_wr = rd_nz;
            end
            OP_AUIPC: begin
                imm_fmt_o           = IMM_U;
                ctrl_o.alu_op       = ALU_ADD;
                ctrl_o.rs1_zero_sel = 1'b1;
                ctrl_o.pc_imm_sel   = 1'b1;
                ctrl_o.pc_alu_sel   = 1'b1;
                ctrl_o.reg_wr       = rd_nz;
            end
            OP_JAL: begin
                imm_fmt_o           = IMM_J;
                ctrl_o.rs1_zero_sel = 1'b1;
                ctrl_o.rs2_imm_sel  = 1'b1;
                ctrl_o.pc_alu_sel   = 1'b1;
                ctrl_o.jump         = 1'b1;
                ctrl_o.reg_wr       = rd_nz;
            end
            OP_JALR: begin
                imm_fmt_o           = IMM_I;
                ctrl_o.alu_op       = ALU_ADD;
                ctrl_o.rs1_zero_sel = 1'b1;
                ctrl_o.pc_alu_sel   = 1'b1;
                ctrl_o.jump_alu     = 1'b1;
                ctrl_o.reg_wr       = rd_nz;
            end
            OP_BRANCH: begin
                imm_fmt_o           = IMM_B;
                ctrl_o.rs1_zero_sel = 1'b1;
                ctrl_o.rs2_imm_sel  = 1'b1;
                ctrl_o.branch       = 1'b1;
                // zcmp means taken when the compare result is zero
                case (fields_i.funct3)
                    FUNCT3_BEQ:  ctrl_o.alu_op = ALU_SUB;
                    FUNCT3_BNE:  ctrl_o.alu_op = ALU_SUB;
                    FUNCT3_BLT:  ctrl_o.alu_op = ALU_SLT;
                    FUNCT3_BGE:  ctrl_o.alu_op = ALU_SLT;
                    FUNCT3_BLTU: ctrl_o.alu_op = ALU_SLTU;
                    FUNCT3_BGEU: ctrl_o.alu_op = ALU_SLTU;
                    default:     op_ill_o      = 1'b1;
                endcase
                ctrl_o.branch_zcmp = fields_i.funct3 == FUNCT3_BEQ
                                   || fields_i.funct3 == FUNCT3_BGE
                                   || fields_i.funct3 == FUNCT3_BGEU;
            end
            // fence and system instructions are not supported
            OP_MISC_MEM, OP_SYSTEM: begin
                op_ill_o = 1'b1;
            end
            OP_LOAD_FP, OP_STORE_FP, OP_AMO, OP_OP_32, OP_OP_IMM_32,
            OP_MADD, OP_MSUB, OP_NMSUB, OP_NMADD, OP_OP_FP,
            OP_CUST_0, OP_CUST_1, OP_CUST_2, OP_CUST_3: begin
            end
            default: begin
                op_ill_o = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/mem_dec.sv
`timescale 1ns/1ps
`default_nettype none

module mem_dec #(
    parameter int XLEN = 32
) (
    input  logic [2:0]        funct3_i,
    input  logic              is_mem_i,
    input  logic              store_i,
    output logic [XLEN/8-1:0] mem_byte_o,
    output logic              mem_sign_ext_o,
    output logic              width_ill_o
);

    import dec_pkg::*;

    localparam int BYTES = XLEN / 8;

    always_comb begin
        mem_byte_o     = '0;
        mem_sign_ext_o = 1'b0;
        width_ill_o    = 1'b0;
        if (is_mem_i && store_i) begin
            // unsigned widths have no store form
            case (funct3_i)
                FUNCT3_SB: mem_byte_o  = BYTES'(4'h1);
                FUNCT3_SH: mem_byte_o  = BYTES'(4'h3);
                FUNCT3_SW: mem_byte_o  = BYTES'(4'hf);
                default:   width_ill_o = 1'b1;
            endcase
        end else if (is_mem_i) begin
            case (funct3_i)
                FUNCT3_LB:  mem_byte_o  = BYTES'(4'h1);
                FUNCT3_LH:  mem_byte_o  = BYTES'(4'h3);
                FUNCT3_LW:  mem_byte_o  = BYTES'(4'hf);
                FUNCT3_LBU: mem_byte_o  = BYTES'(4'h1);
                FUNCT3_LHU: mem_byte_o  = BYTES'(4'h3);
                default:    width_ill_o = 1'b1;
            endcase
            mem_sign_ext_o = funct3_i == FUNCT3_LB || funct3_i == FUNCT3_LH
                          || funct3_i == FUNCT3_LW;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module dec_tb -f filelist.f -Mdir obj_dir -o dec_sim
if [ $? -ne 0 ]; then
    echo "run_sim: build failed"
    exit 1
fi

./obj_dir/dec_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "run_sim: FAIL"
    exit 1
fi

echo "run_sim: PASS"
exit 0

// File: verif/dec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dec_tb;

    import dec_pkg::*;

    localparam int XLEN         = 32;
    localparam int RESET_CYCLES = 8;
    localparam int N_RANDOM     = 300;
    // directed list stays under 100 words plus one drain cycle and some slack
    localparam int MAX_CYCLES   = RESET_CYCLES + 100 + N_RANDOM + 40;

    // RV32I funct3 table for OP and OP-IMM
    localparam logic [3:0] ALU_BY_F3 [8] = '{
        ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND
    };

    localparam logic [4:0] KEPT_OPS [9] = '{
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE, OP_OP_IMM, OP_OP
    };

    typedef struct packed {
        logic        valid;
        logic [3:0]  alu_op;
        logic        rs1_zero_sel;
        logic        rs2_imm_sel;
        logic        pc_imm_sel;
        logic        pc_alu_sel;
        logic        branch;
        logic        branch_zcmp;
        logic        jump;
        logic        jump_alu;
        logic        mem_req;
        logic        mem_wr;
        logic        mem_cal_sel;
        logic        reg_wr;
        logic [31:0] imm;
        logic [3:0]  mem_byte;
        logic        sign_ext;
        logic        ill;
    } exp_t;

    logic              clk;
    logic              arst_n;
    logic [31:0]       inst;
    logic              inst_valid;
    logic              dec_valid;
    ctrl_t             ctrl;
    logic [XLEN-1:0]   imm;
    logic [XLEN/8-1:0] mem_byte;
    logic              mem_sign_ext;
    logic              ill_inst;

    exp_t        pending;
    logic [31:0] pending_inst;
    integer      seed;
    int          checks;
    int          errors;
    int          cycles;
    logic        timed_out;

    dec_top #(
        .XLEN (XLEN)
    ) dut0 (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .inst_i         (inst),
        .inst_valid_i   (inst_valid),
        .dec_valid_o    (dec_valid),
        .ctrl_o         (ctrl),
        .imm_o          (imm),
        .mem_byte_o     (mem_byte),
        .mem_sign_ext_o (mem_sign_ext),
        .ill_inst_o     (ill_inst)
    );

    bind dec_top dec_tb_checker #(
        .XLEN (XLEN)
    ) u_checker (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .inst_valid_i   (inst_valid_i),
        .dec_valid_o    (dec_valid_o),
        .ctrl_o         (ctrl_o),
        .imm_o          (imm_o),
        .mem_byte_o     (mem_byte_o),
        .mem_sign_ext_o (mem_sign_ext_o),
        .ill_inst_o     (ill_inst_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            timed_out = 1'b1;
            finish_run();
        end
    end

    function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] op);
        return {f7, rs2, rs1, f3, rd, op, 2'b11};
    endfunction

    // expected decode from the RV32I encoding rules
    function automatic exp_t predict(input logic [31:0] w, input logic v);
        exp_t       e;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       wr;
        logic       legal;
        logic [3:0] mask;
        e = '0;
        if (!v) begin
            return e;
        end
        f3    = w[14:12];
        f7    = w[31:25];
        wr    = w[11:7] != 5'd0;
        mask  = (f3[1:0] == 2'd0) ? 4'h1 : (f3[1:0] == 2'd1) ? 4'h3 : 4'hf;
        e.valid = 1'b1;
        e.ill   = w[1:0] != 2'b11;
        case (w[6:2])
            OP_LUI: begin
                e.alu_op = ALU_OR;
                e.reg_wr = wr;
                e.imm    = {w[31:12], 12'h000};
            end
            OP_AUIPC: begin
                e.rs1_zero_sel = 1'b1;
                e.pc_imm_sel   = 1'b1;
                e.pc_alu_sel   = 1'b1;
                e.reg_wr       = wr;
                e.imm          = {w[31:12], 12'h000};
            end
            OP_JAL: begin
                e.rs1_zero_sel = 1'b1;
                e.rs2_imm_sel  = 1'b1;
                e.pc_alu_sel   = 1'b1;
                e.jump         = 1'b1;
                e.reg_wr       = wr;
                e.imm          = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            OP_JALR: begin
                e.rs1_zero_sel = 1'b1;
                e.pc_alu_sel   = 1'b1;
                e.jump_alu     = 1'b1;
                e.reg_wr       = wr;
                e.imm          = {{20{w[31]}}, w[31:20]};
            end
            OP_BRANCH: begin
                e.rs1_zero_sel = 1'b1;
                e.rs2_imm_sel  = 1'b1;
                e.branch       = 1'b1;
                e.imm          = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                e.branch_zcmp  = f3 == 3'd0 || f3 == 3'd5 || f3 == 3'd7;
                if (f3 == 3'd2 || f3 == 3'd3) begin
                    e.ill = 1'b1;
                end else if (!f3[2]) begin
                    e.alu_op = ALU_SUB;
                end else if (!f3[1]) begin
                    e.alu_op = ALU_SLT;
                end else begin
                    e.alu_op = ALU_SLTU;
                end
            end
            OP_LOAD: begin
                legal          = f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7;
                e.rs1_zero_sel = 1'b1;
                e.mem_req      = 1'b1;
                e.mem_cal_sel  = 1'b1;
                e.reg_wr       = wr;
                e.imm          = {{20{w[31]}}, w[31:20]};
                e.mem_byte     = legal ? mask : 4'h0;
                e.sign_ext     = legal && !f3[2];
                e.ill          = e.ill | !legal;
            end
            OP_STORE: begin
                legal          = f3 < 3'd3;
                e.rs1_zero_sel = 1'b1;
                e.mem_req      = 1'b1;
                e.mem_wr       = 1'b1;
                e.imm          = {{20{w[31]}}, w[31:25], w[11:7]};
                e.mem_byte     = legal ? mask : 4'h0;
                e.ill          = e.ill | !legal;
            end
            OP_OP_IMM: begin
                e.alu_op       = ALU_BY_F3[f3];
                e.rs1_zero_sel = 1'b1;
                e.reg_wr       = wr;
                e.imm          = {{20{w[31]}}, w[31:20]};
                if (f3 == 3'd1 && f7 != 7'h00) begin
                    e.ill = 1'b1;
                end else if (f3 == 3'd5 && f7 == 7'h20) begin
                    e.alu_op = ALU_SRA;
                end else if (f3 == 3'd5 && f7 != 7'h00) begin
                    e.ill = 1'b1;
                end
            end
            OP_OP: begin
                e.alu_op       = ALU_BY_F3[f3];
                e.rs1_zero_sel = 1'b1;
                e.rs2_imm_sel  = 1'b1;
                e.reg_wr       = wr;
                if (f7 == 7'h20 && f3 == 3'd0) begin
                    e.alu_op = ALU_SUB;
                end else if (f7 == 7'h20 && f3 == 3'd5) begin
                    e.alu_op = ALU_SRA;
                end else if (f7 != 7'h00) begin
                    e.ill = 1'b1;
                end
            end
            // reserved, FP, AMO, 32-bit and custom opcodes decode as no-ops
            5'b00001, 5'b00010, 5'b00110, 5'b01001, 5'b01010, 5'b01011, 5'b01110,
            5'b10000, 5'b10001, 5'b10010, 5'b10011, 5'b10100, 5'b10110, 5'b11110: begin
            end
            default: begin
                e.ill = 1'b1;
            end
        endcase
        return e;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (exp === got) else begin
            errors++;
            $display("Error %s exp %h got %h (inst %h)", name, exp, got, pending_inst);
        end
    endtask

    task automatic compare_outputs;
        check_field("dec_valid_o", 32'(pending.valid), 32'(dec_valid));
        check_field("ctrl_o.alu_op", 32'(pending.alu_op), 32'(ctrl.alu_op));
        check_field("ctrl_o.rs1_zero_sel", 32'(pending.rs1_zero_sel), 32'(ctrl.rs1_zero_sel));
        check_field("ctrl_o.rs2_imm_sel", 32'(pending.rs2_imm_sel), 32'(ctrl.rs2_imm_sel));
        check_field("ctrl_o.pc_imm_sel", 32'(pending.pc_imm_sel), 32'(ctrl.pc_imm_sel));
        check_field("ctrl_o.pc_alu_sel", 32'(pending.pc_alu_sel), 32'(ctrl.pc_alu_sel));
        check_field("ctrl_o.branch", 32'(pending.branch), 32'(ctrl.branch));
        check_field("ctrl_o.branch_zcmp", 32'(pending.branch_zcmp), 32'(ctrl.branch_zcmp));
        check_field("ctrl_o.jump", 32'(pending.jump), 32'(ctrl.jump));
        check_field("ctrl_o.jump_alu", 32'(pending.jump_alu), 32'(ctrl.jump_alu));
        check_field("ctrl_o.mem_req", 32'(pending.mem_req), 32'(ctrl.mem_req));
        check_field("ctrl_o.mem_wr", 32'(pending.mem_wr), 32'(ctrl.mem_wr));
        check_field("ctrl_o.mem_cal_sel", 32'(pending.mem_cal_sel), 32'(ctrl.mem_cal_sel));
        check_field("ctrl_o.reg_wr", 32'(pending.reg_wr), 32'(ctrl.reg_wr));
        check_field("imm_o", pending.imm, imm);
        check_field("mem_byte_o", 32'(pending.mem_byte), 32'(mem_byte));
        check_field("mem_sign_ext_o", 32'(pending.sign_ext), 32'(mem_sign_ext));
        check_field("ill_inst_o", 32'(pending.ill), 32'(ill_inst));
    endtask

    // outputs of the word driven one cycle earlier are checked before the next drive
    task automatic apply(input logic [31:0] w, input logic v);
        @(posedge clk);
        #1;
        compare_outputs();
        #1;
        inst         = w;
        inst_valid   = v;
        pending      = predict(w, v);
        pending_inst = w;
    endtask

    task automatic run_directed;
        logic [6:0] f7;
        for (int f = 0; f < 8; f++) begin
            apply(enc(FUNCT7_BASE, 5'd3, 5'd2, f[2:0], 5'd5, OP_OP), 1'b1);
        end
        apply(enc(FUNCT7_ALT, 5'd3, 5'd2, FUNCT3_ADD, 5'd5, OP_OP), 1'b1);
        apply(enc(FUNCT7_ALT, 5'd3, 5'd2, FUNCT3_SRL, 5'd5, OP_OP), 1'b1);
        apply(enc(FUNCT7_ALT, 5'd3, 5'd2, FUNCT3_SLL, 5'd5, OP_OP), 1'b1);
        apply(enc(7'h01, 5'd3, 5'd2, FUNCT3_ADD, 5'd5, OP_OP), 1'b1);
        apply(enc(FUNCT7_BASE, 5'd3, 5'd2, FUNCT3_ADD, 5'd0, OP_OP), 1'b1);
        // bubbles with one live word on the bus
        apply(32'h0, 1'b0);
        apply(enc(FUNCT7_BASE, 5'd3, 5'd2, FUNCT3_ADD, 5'd5, OP_OP), 1'b0);
        apply(32'h0, 1'b0);
        for (int f = 0; f < 8; f++) begin
            f7 = (f == 1 || f == 5) ? FUNCT7_BASE : 7'h55;
            apply(enc(f7, 5'h1a, 5'd4, f[2:0], 5'd6, OP_OP_IMM), 1'b1);
        end
        apply(enc(FUNCT7_ALT, 5'd7, 5'd4, FUNCT3_SRL, 5'd6, OP_OP_IMM), 1'b1);
        apply(enc(FUNCT7_ALT, 5'd7, 5'd4, FUNCT3_SLL, 5'd6, OP_OP_IMM), 1'b1);
        apply(enc(7'h01, 5'd7, 5'd4, FUNCT3_SRL, 5'd6, OP_OP_IMM), 1'b1);
        // every funct3 code as load, store and branch
        for (int f = 0; f < 8; f++) begin
            apply(enc(7'h4b, 5'h11, 5'd8, f[2:0], 5'd9, OP_LOAD), 1'b1);
            apply(enc(7'h2d, 5'h11, 5'd8, f[2:0], 5'h1e, OP_STORE), 1'b1);
            apply(enc(7'h4b, 5'h11, 5'd8, f[2:0], 5'h15, OP_BRANCH), 1'b1);
        end
        apply(enc(7'h4b, 5'h11, 5'd8, FUNCT3_LW, 5'd0, OP_LOAD), 1'b1);
        apply(enc(7'h6a, 5'h15, 5'h0b, 3'h6, 5'd9, OP_LUI), 1'b1);
        apply(enc(7'h1a, 5'h0e, 5'h13, 3'h2, 5'd9, OP_AUIPC), 1'b1);
        apply(enc(7'h6a, 5'h0d, 5'h17, 3'h5, 5'd1, OP_JAL), 1'b1);
        apply(enc(7'h35, 5'h12, 5'h08, 3'h3, 5'd0, OP_JAL), 1'b1);
        apply(enc(7'h45, 5'h1f, 5'h01, 3'h0, 5'd1, OP_JALR), 1'b1);
        // broken low bits
        apply(enc(FUNCT7_BASE, 5'd3, 5'd2, FUNCT3_ADD, 5'd5, OP_OP) ^ 32'h1, 1'b1);
        apply(enc(FUNCT7_BASE, 5'd3, 5'd2, FUNCT3_ADD, 5'd5, OP_OP) ^ 32'h2, 1'b1);
        apply(enc(FUNCT7_BASE, 5'd3, 5'd2, FUNCT3_ADD, 5'd5, OP_OP) ^ 32'h3, 1'b1);
        // whole opcode map
        for (int op = 0; op < 32; op++) begin
            apply(enc(FUNCT7_BASE, 5'd1, 5'd2, 3'd0, 5'd3, op[4:0]), 1'b1);
        end
    endtask

    task automatic run_random;
        logic [31:0] w;
        logic [31:0] sel;
        int          idx;
        for (int n = 0; n < N_RANDOM; n++) begin
            w   = $random(seed);
            sel = $random(seed);
            // mostly well-formed words with half of them on a decoded opcode
            if (sel[2:0] != 3'd0) begin
                w[1:0] = 2'b11;
            end
            if (sel[3]) begin
                idx    = sel[7:4] % 9;
                w[6:2] = KEPT_OPS[idx];
            end
            apply(w, sel[10:8] != 3'd0);
        end
    endtask

    task automatic finish_run;
        int asrt_fails;
        asrt_fails = dut0.u_checker.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    initial begin
        seed         = 32'h30c6e2ec;
        checks       = 0;
        errors       = 0;
        cycles       = 0;
        timed_out    = 1'b0;
        inst         = '0;
        inst_valid   = 1'b0;
        arst_n       = 1'b1;
        pending      = '0;
        pending_inst = '0;
        #1;
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;
        run_directed();
        run_random();
        // drain the last word
        apply(32'h0, 1'b0);
        finish_run();
    end

endmodule

`default_nettype wire

// File: verif/dec_tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dec_tb_checker #(
    parameter int XLEN = 32
) (
    input logic              clk_i,
    input logic              arst_n_i,
    input logic              inst_valid_i,
    input logic              dec_valid_o,
    input dec_pkg::ctrl_t    ctrl_o,
    input logic [XLEN-1:0]   imm_o,
    input logic [XLEN/8-1:0] mem_byte_o,
    input logic              mem_sign_ext_o,
    input logic              ill_inst_o
);

    // read by the testbench at the end of the run
    int fail_cnt = 0;

    // one stage, one cycle
    valid_tracks_input: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) dec_valid_o == $past(inst_valid_i)
    ) else begin
        fail_cnt++;
        $error("dec_valid_o does not follow inst_valid_i of the previous cycle");
    end

    store_needs_req: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) ctrl_o.mem_wr |-> ctrl_o.mem_req
    ) else begin
        fail_cnt++;
        $error("mem_wr set without mem_req");
    end

    branch_no_writeback: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) ctrl_o.branch |-> !ctrl_o.reg_wr
    ) else begin
        fail_cnt++;
        $error("branch decoded with reg_wr set");
    end

    zero_in_reset: assert property (
        @(posedge clk_i) !arst_n_i |-> (!dec_valid_o && ctrl_o == '0 && imm_o == '0
            && mem_byte_o == '0 && !mem_sign_ext_o && !ill_inst_o)
    ) else begin
        fail_cnt++;
        $error("outputs not cleared while reset is held");
    end

endmodule

`default_nettype wire
